/* common/vic_defines.svh */
`ifndef VIC_DEFINES_SVH
`define VIC_DEFINES_SVH

// --------------------------------------------------------------------------
// raster limits, 6569 PAL
// --------------------------------------------------------------------------
`define RASTER_X_MAX      10'd503
`define RASTER_Y_MAX      9'd311

// composite sync spans
`define HSYNC_START       10'd408
`define HSYNC_END         10'd443
`define VSYNC_START       9'd301
`define VSYNC_END         9'd308

// --------------------------------------------------------------------------
// border window, rows for rsel=1 / rsel=0, pixels for csel=1 / csel=0
// --------------------------------------------------------------------------
`define BORDER_TOP_25     9'd51
`define BORDER_BOTTOM_25  9'd251
`define BORDER_TOP_24     9'd55
`define BORDER_BOTTOM_24  9'd247
`define BORDER_LEFT_40    10'd24
`define BORDER_RIGHT_40   10'd344
`define BORDER_LEFT_38    10'd31
`define BORDER_RIGHT_38   10'd335

// register map, only the kept registers
`define REG_CTRL1         6'h11
`define REG_RASTER        6'h12
`define REG_CTRL2         6'h16
`define REG_IRQ_STATUS    6'h19
`define REG_IRQ_ENABLE    6'h1A
`define REG_BORDER        6'h20
`define REG_BACKGROUND    6'h21

`endif

/* common/vicPkg.sv */
`default_nettype none

package vicPkg;

  // --------------------------------------------------------------------------
  // raster position
  // --------------------------------------------------------------------------

  // pixel number within a line, 0..503
  typedef logic [9:0] rasterX_t;

  // line number within a frame, 0..311
  typedef logic [8:0] rasterLine_t;

  // --------------------------------------------------------------------------
  // register bus
  // --------------------------------------------------------------------------

  // register address, 64 slots
  typedef logic [5:0] regAddr_t;

  // register data byte
  typedef logic [7:0] busData_t;

  // palette index for border and background
  typedef logic [3:0] colorIndex_t;

endpackage

`default_nettype wire

/* rasterTiming/rasterTiming.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vic_defines.svh"

module rasterTiming import vicPkg::*; (
  input  wire logic  clk_dot4x,
  input  wire logic  rst,
  output rasterX_t    rasterX,
  output rasterLine_t rasterLine,
  output logic        dotTick,
  output logic        lineStart,
  output logic        cSync
);

  // --------------------------------------------------------------------------
  // dot divider
  // --------------------------------------------------------------------------

  // one-hot ring, one bit walks through four dot4x cycles
  logic [3:0] dotDiv;

  // sync decode of the current position
  logic hSyncArea;
  logic vSyncArea;

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dotDiv <= 4'b0001;
    end else begin
      dotDiv <= {dotDiv[2:0], dotDiv[3]};
    end
  end

  // top bit of the ring marks the pixel step
  assign dotTick = dotDiv[3];

  // --------------------------------------------------------------------------
  // raster counters
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX    <= '0;
      rasterLine <= '0;
    end else if (dotTick) begin
      if (rasterX == `RASTER_X_MAX) begin
        rasterX <= '0;
        // end of line, step or wrap the line counter
        if (rasterLine == `RASTER_Y_MAX) begin
          rasterLine <= '0;
        end else begin
          rasterLine <= rasterLine + 9'd1;
        end
      end else begin
        rasterX <= rasterX + 10'd1;
      end
    end
  end

  // first pixel of every line
  assign lineStart = dotTick && (rasterX == '0);

  // --------------------------------------------------------------------------
  // composite sync
  // --------------------------------------------------------------------------

  assign hSyncArea = (rasterX >= `HSYNC_START) && (rasterX <= `HSYNC_END);
  assign vSyncArea = (rasterLine >= `VSYNC_START) && (rasterLine <= `VSYNC_END);

  // active low, one clock behind the position
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      cSync <= 1'b1;
    end else begin
      cSync <= ~(hSyncArea | vSyncArea);
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // counter must wrap before running off the line
  xInRange: assert property (@(posedge clk_dot4x) disable iff (rst)
    rasterX <= `RASTER_X_MAX)
    else $error("rasterX beyond last pixel");

  // line start only ever on a pixel step
  lineStartOnTick: assert property (@(posedge clk_dot4x) disable iff (rst)
    lineStart |-> dotTick)
    else $error("lineStart without dotTick");

endmodule

`default_nettype wire

/* source/registerBank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vic_defines.svh"

module registerBank import vicPkg::*; (
  input  wire logic        clk_dot4x,
  input  wire logic        rst,
  input  wire logic        ce,
  input  wire logic        rw,
  input  wire regAddr_t    adi,
  input  wire busData_t    dbi,
  output busData_t         dbo,
  input  wire rasterLine_t rasterLine,
  input  wire logic        lineStart,
  output logic             irq,
  output logic             rsel,
  output logic             csel,
  output logic             den,
  output colorIndex_t      borderColor,
  output colorIndex_t      backgroundColor
);

  // --------------------------------------------------------------------------
  // bus strobes
  // --------------------------------------------------------------------------

  logic writeEn;
  logic readEn;

  // 9-bit compare value with bit 8 in CTRL1
  rasterLine_t rasterCmp;

  // raster interrupt latch and its enable
  logic irqStatus;
  logic irqEnable;

  logic rasterHit;
  logic clearStatus;
  busData_t readData;

  // any edge with ce low is an access
  assign writeEn = !ce && !rw;
  assign readEn  = !ce && rw;

  // --------------------------------------------------------------------------
  // control registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rsel            <= 1'b1;
      csel            <= 1'b1;
      den             <= 1'b1;
      rasterCmp       <= '0;
      irqEnable       <= 1'b0;
      borderColor     <= '0;
      backgroundColor <= '0;
    end else if (writeEn) begin
      case (adi)
        `REG_CTRL1: begin
          rsel         <= dbi[3];
          den          <= dbi[4];
          rasterCmp[8] <= dbi[7];
        end
        `REG_RASTER:     rasterCmp[7:0]  <= dbi;
        `REG_CTRL2:      csel            <= dbi[3];
        `REG_IRQ_ENABLE: irqEnable       <= dbi[0];
        `REG_BORDER:     borderColor     <= dbi[3:0];
        `REG_BACKGROUND: backgroundColor <= dbi[3:0];
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // raster interrupt
  // --------------------------------------------------------------------------

  // compare once per line on its first pixel
  assign rasterHit   = lineStart && (rasterLine == rasterCmp);
  assign clearStatus = writeEn && (adi == `REG_IRQ_STATUS) && dbi[0];

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      irqStatus <= 1'b0;
    end else if (rasterHit) begin
      // a new hit wins over a clear in the same cycle
      irqStatus <= 1'b1;
    end else if (clearStatus) begin
      irqStatus <= 1'b0;
    end
  end

  // status latches on its own and the enable only gates the pin
  assign irq = irqStatus & irqEnable;

  // --------------------------------------------------------------------------
  // read-back
  // --------------------------------------------------------------------------

  // unused bits and unused addresses read as ones
  always_comb begin
    case (adi)
      `REG_CTRL1:      readData = {rasterLine[8], 2'b11, den, rsel, 3'b111};
      `REG_RASTER:     readData = rasterLine[7:0];
      `REG_CTRL2:      readData = {4'hF, csel, 3'b111};
      `REG_IRQ_STATUS: readData = {~irq, 6'h3F, irqStatus};
      `REG_IRQ_ENABLE: readData = {7'h7F, irqEnable};
      `REG_BORDER:     readData = {4'hF, borderColor};
      `REG_BACKGROUND: readData = {4'hF, backgroundColor};
      default:         readData = 8'hFF;
    endcase
  end

  // dbo holds between reads
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dbo <= 8'hFF;
    end else if (readEn) begin
      dbo <= readData;
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  irqNeedsEnable: assert property (@(posedge clk_dot4x) disable iff (rst)
    !irqEnable |-> !irq)
    else $error("irq high with enable off");

endmodule

`default_nettype wire

/* source/videoOutput.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vic_defines.svh"

module videoOutput import vicPkg::*; (
  input  wire logic        clk_dot4x,
  input  wire logic        rst,
  input  wire rasterX_t    rasterX,
  input  wire rasterLine_t rasterLine,
  input  wire logic        dotTick,
  input  wire logic        rsel,
  input  wire logic        csel,
  input  wire logic        den,
  input  wire colorIndex_t borderColor,
  input  wire colorIndex_t backgroundColor,
  output colorIndex_t      colorIndex
);

  // --------------------------------------------------------------------------
  // border window
  // --------------------------------------------------------------------------

  // top/bottom and left/right border flags
  logic vBorder;
  logic hBorder;

  // window edges for the current rsel/csel
  rasterLine_t topRow;
  rasterLine_t bottomRow;
  rasterX_t    leftPix;
  rasterX_t    rightPix;

  assign topRow    = rsel ? `BORDER_TOP_25    : `BORDER_TOP_24;
  assign bottomRow = rsel ? `BORDER_BOTTOM_25 : `BORDER_BOTTOM_24;
  assign leftPix   = csel ? `BORDER_LEFT_40   : `BORDER_LEFT_38;
  assign rightPix  = csel ? `BORDER_RIGHT_40  : `BORDER_RIGHT_38;

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      vBorder <= 1'b1;
      hBorder <= 1'b1;
    end else if (dotTick) begin
      // vertical opens only with display enabled
      if (rasterLine == bottomRow) begin
        vBorder <= 1'b1;
      end else if ((rasterLine == topRow) && den) begin
        vBorder <= 1'b0;
      end
      // side border follows the vertical flag at the left edge
      if (rasterX == leftPix) begin
        hBorder <= vBorder;
      end else if (rasterX == rightPix) begin
        hBorder <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // colour index
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      colorIndex <= '0;
    end else begin
      colorIndex <= (vBorder | hBorder) ? borderColor : backgroundColor;
    end
  end

endmodule

`default_nettype wire

/* source/vicVideo.sv */
`timescale 1ns/10ps
`default_nettype none

module vicVideo import vicPkg::*; (
  input  wire logic        clk_dot4x,
  input  wire logic        rst,
  input  wire logic        ce,
  input  wire logic        rw,
  input  wire regAddr_t    adi,
  input  wire busData_t    dbi,
  output busData_t         dbo,
  output logic             irq,
  output logic             cSync,
  output colorIndex_t      colorIndex
);

  // --------------------------------------------------------------------------
  // raster position and pixel step
  // --------------------------------------------------------------------------
  rasterX_t    rasterX;
  rasterLine_t rasterLine;
  logic        dotTick;
  logic        lineStart;

  // register outputs into the video path
  logic        rsel;
  logic        csel;
  logic        den;
  colorIndex_t borderColor;
  colorIndex_t backgroundColor;

  rasterTiming u_rasterTiming (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .rasterX    (rasterX),
    .rasterLine (rasterLine),
    .dotTick    (dotTick),
    .lineStart  (lineStart),
    .cSync      (cSync)
  );

  // chip register bus and raster interrupt
  registerBank u_registerBank (
    .clk_dot4x       (clk_dot4x),
    .rst             (rst),
    .ce              (ce),
    .rw              (rw),
    .adi             (adi),
    .dbi             (dbi),
    .dbo             (dbo),
    .rasterLine      (rasterLine),
    .lineStart       (lineStart),
    .irq             (irq),
    .rsel            (rsel),
    .csel            (csel),
    .den             (den),
    .borderColor     (borderColor),
    .backgroundColor (backgroundColor)
  );

  // border window and colour select
  videoOutput u_videoOutput (
    .clk_dot4x       (clk_dot4x),
    .rst             (rst),
    .rasterX         (rasterX),
    .rasterLine      (rasterLine),
    .dotTick         (dotTick),
    .rsel            (rsel),
    .csel            (csel),
    .den             (den),
    .borderColor     (borderColor),
    .backgroundColor (backgroundColor),
    .colorIndex      (colorIndex)
  );

endmodule

`default_nettype wire

/* verification/tbVicVideo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vic_defines.svh"

module tbVicVideo import vicPkg::*; ();

  // one PAL frame in dot4x cycles (504 pixels x 312 lines x 4)
  localparam int FRAME_CYCLES   = 504 * 312 * 4;
  // two random frames and at most two frames of interrupt waits
  localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 4096;

  logic        clk_dot4x;
  logic        rst;
  logic        ce;
  logic        rw;
  regAddr_t    adi;
  busData_t    dbi;
  busData_t    dbo;
  logic        irq;
  logic        cSync;
  colorIndex_t colorIndex;

  logic [31:0] lfsrState = 32'hfa73;
  int          cycleCount = 0;
  int          errorCount = 0;

  // reference model state
  logic [1:0]  mDiv;
  rasterX_t    mX;
  rasterLine_t mLine;
  logic        mV;
  logic        mH;
  logic        mRsel;
  logic        mCsel;
  logic        mDen;
  logic        mStatus;
  logic        mEnable;
  logic        mCsync;
  rasterLine_t mCmp;
  colorIndex_t mBorder;
  colorIndex_t mBg;
  colorIndex_t mColor;
  busData_t    mDbo;

  vicVideo u_dut (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .ce         (ce),
    .rw         (rw),
    .adi        (adi),
    .dbi        (dbi),
    .dbo        (dbo),
    .irq        (irq),
    .cSync      (cSync),
    .colorIndex (colorIndex)
  );

  initial begin
    clk_dot4x = 1'b0;
    forever #10 clk_dot4x = ~clk_dot4x;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      errorCount++;
      abortRun($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // galois shift with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one shift per bit with the msb first
  task automatic randomBits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  function automatic regAddr_t keptAddr(input logic [2:0] idx);
    case (idx)
      3'd0:    return `REG_CTRL1;
      3'd1:    return `REG_RASTER;
      3'd2:    return `REG_CTRL2;
      3'd3:    return `REG_IRQ_STATUS;
      3'd4:    return `REG_IRQ_ENABLE;
      3'd5:    return `REG_BORDER;
      default: return `REG_BACKGROUND;
    endcase
  endfunction

  // register read-back with unused bits and addresses as ones
  function automatic busData_t expectedRead(input regAddr_t a);
    case (a)
      `REG_CTRL1:      return {mLine[8], 2'b11, mDen, mRsel, 3'b111};
      `REG_RASTER:     return mLine[7:0];
      `REG_CTRL2:      return {4'hF, mCsel, 3'b111};
      `REG_IRQ_STATUS: return {~(mStatus & mEnable), 6'h3F, mStatus};
      `REG_IRQ_ENABLE: return {7'h7F, mEnable};
      `REG_BORDER:     return {4'hF, mBorder};
      `REG_BACKGROUND: return {4'hF, mBg};
      default:         return 8'hFF;
    endcase
  endfunction

  task automatic busWrite(input regAddr_t a, input busData_t d);
    @(posedge clk_dot4x);
    ce  <= 1'b0;
    rw  <= 1'b0;
    adi <= a;
    dbi <= d;
    @(posedge clk_dot4x);
    ce  <= 1'b1;
    rw  <= 1'b1;
  endtask

  task automatic busRead(input regAddr_t a);
    @(posedge clk_dot4x);
    ce  <= 1'b0;
    rw  <= 1'b1;
    adi <= a;
    @(posedge clk_dot4x);
    ce  <= 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // reference model stepped on the same edge as the DUT
  // --------------------------------------------------------------------------
  always @(posedge clk_dot4x) begin : refModel
    logic tick;
    logic wrEn;
    logic hit;
    if (rst) begin
      mDiv    = 2'd0;
      mX      = '0;
      mLine   = '0;
      mV      = 1'b1;
      mH      = 1'b1;
      mRsel   = 1'b1;
      mCsel   = 1'b1;
      mDen    = 1'b1;
      mStatus = 1'b0;
      mEnable = 1'b0;
      mCmp    = '0;
      mBorder = '0;
      mBg     = '0;
      mColor  = '0;
      mDbo    = 8'hFF;
      mCsync  = 1'b1;
    end else begin
      tick = (mDiv == 2'd3);
      wrEn = !ce && !rw;
      hit  = tick && (mX == '0) && (mLine == mCmp);
      // registered outputs see the state before this edge
      if (!ce && rw) begin
        mDbo = expectedRead(adi);
      end
      mCsync = !(((mX >= `HSYNC_START) && (mX <= `HSYNC_END)) ||
                 ((mLine >= `VSYNC_START) && (mLine <= `VSYNC_END)));
      mColor = (mV || mH) ? mBorder : mBg;
      if (tick) begin
        // side flag takes the old vertical flag
        if (mX == (mCsel ? `BORDER_LEFT_40 : `BORDER_LEFT_38)) begin
          mH = mV;
        end else if (mX == (mCsel ? `BORDER_RIGHT_40 : `BORDER_RIGHT_38)) begin
          mH = 1'b1;
        end
        if (mLine == (mRsel ? `BORDER_BOTTOM_25 : `BORDER_BOTTOM_24)) begin
          mV = 1'b1;
        end else if ((mLine == (mRsel ? `BORDER_TOP_25 : `BORDER_TOP_24)) && mDen) begin
          mV = 1'b0;
        end
      end
      if (hit) begin
        mStatus = 1'b1;
      end else if (wrEn && (adi == `REG_IRQ_STATUS) && dbi[0]) begin
        mStatus = 1'b0;
      end
      if (wrEn) begin
        case (adi)
          `REG_CTRL1: begin
            mRsel   = dbi[3];
            mDen    = dbi[4];
            mCmp[8] = dbi[7];
          end
          `REG_RASTER:     mCmp[7:0] = dbi;
          `REG_CTRL2:      mCsel     = dbi[3];
          `REG_IRQ_ENABLE: mEnable   = dbi[0];
          `REG_BORDER:     mBorder   = dbi[3:0];
          `REG_BACKGROUND: mBg       = dbi[3:0];
          default: ;
        endcase
      end
      if (tick) begin
        if (mX == `RASTER_X_MAX) begin
          mX    = '0;
          mLine = (mLine == `RASTER_Y_MAX) ? 9'd0 : mLine + 9'd1;
        end else begin
          mX = mX + 10'd1;
        end
      end
      mDiv = mDiv + 2'd1;
    end
  end

  // outputs compared half a cycle after the edge
  always @(negedge clk_dot4x) begin
    if (!rst) begin
      checkValue("dbo", 32'(dbo), 32'(mDbo));
      checkValue("irq", 32'(irq), 32'(mStatus & mEnable));
      checkValue("cSync", 32'(cSync), 32'(mCsync));
      checkValue("colorIndex", 32'(colorIndex), 32'(mColor));
    end
  end

  always @(posedge clk_dot4x) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      abortRun("timeout: the run went past its cycle limit");
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] op;
    logic [31:0] pick;
    logic [31:0] data;
    rasterLine_t cmpLine;
    int          waited;
    rst = 1'b1;
    ce  = 1'b1;
    rw  = 1'b1;
    adi = '0;
    dbi = '0;
    repeat (5) @(posedge clk_dot4x);
    rst <= 1'b0;

    // two frames of random reads with rare random writes
    for (int cyc = 0; cyc < 2 * FRAME_CYCLES; cyc++) begin
      @(posedge clk_dot4x);
      randomBits(4, op);
      randomBits(8, pick);
      ce <= 1'b1;
      rw <= 1'b1;
      if ((op >= 8) && (op < 15)) begin
        randomBits(6, data);
        adi <= pick[0] ? keptAddr(3'(pick[3:1] % 7)) : data[5:0];
        ce  <= 1'b0;
      end else if ((op == 15) && (pick == 0)) begin
        randomBits(10, data);
        case (data[9:8])
          2'd0:    adi <= `REG_BORDER;
          2'd1:    adi <= `REG_BACKGROUND;
          2'd2:    adi <= `REG_CTRL1;
          default: adi <= `REG_CTRL2;
        endcase
        dbi <= data[7:0];
        ce  <= 1'b0;
        rw  <= 1'b0;
      end
    end

    // raster interrupt on a random line
    randomBits(9, data);
    cmpLine = rasterLine_t'(data % 312);
    busWrite(`REG_CTRL1, {cmpLine[8], 2'b00, 1'b1, 1'b1, 3'b000});
    busWrite(`REG_RASTER, cmpLine[7:0]);
    busWrite(`REG_IRQ_STATUS, 8'h01);
    busWrite(`REG_IRQ_ENABLE, 8'h01);
    waited = 0;
    do begin
      @(negedge clk_dot4x);
      waited++;
      if (waited > FRAME_CYCLES + 64) begin
        abortRun("irq did not rise within a frame of enabling the raster compare");
      end
    end while (!irq);

    // the line registers still show the compare line
    busRead(`REG_RASTER);
    @(negedge clk_dot4x);
    checkValue("raster at irq", 32'(dbo), 32'(cmpLine[7:0]));
    busRead(`REG_CTRL1);
    @(negedge clk_dot4x);
    checkValue("line bit 8 at irq", 32'(dbo[7]), 32'(cmpLine[8]));

    busWrite(`REG_IRQ_STATUS, 8'h01);
    @(negedge clk_dot4x);
    checkValue("irq after clear", 32'(irq), 32'h0);

    // with the enable off the status bit still latches
    busWrite(`REG_IRQ_ENABLE, 8'h00);
    repeat (FRAME_CYCLES + 16) begin
      @(negedge clk_dot4x);
      checkValue("irq disabled", 32'(irq), 32'h0);
    end
    busRead(`REG_IRQ_STATUS);
    @(negedge clk_dot4x);
    checkValue("dbo status", 32'(dbo), 32'hFF);

    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abortRun("checks failed during the run");
    end
  end

endmodule

`default_nettype wire

/* vicVideo.f */
+incdir+common
common/vicPkg.sv
rasterTiming/rasterTiming.sv
source/registerBank.sv
source/videoOutput.sv
source/vicVideo.sv
verification/tbVicVideo.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = tbVicVideo
FILELIST = vicVideo.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
